// File: logic/core_pkg.sv
package core_pkg;

    localparam int xlen = 32;
    localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

    // Iteration count of the multiplier and the divider
    localparam int muldiv_cycles = 32;

    localparam logic [6:0] opc_lui   = 7'b0110111;
    localparam logic [6:0] opc_jal   = 7'b1101111;
    localparam logic [6:0] opc_jalr  = 7'b1100111;
    localparam logic [6:0] opc_opimm = 7'b0010011;
    localparam logic [6:0] opc_op    = 7'b0110011;

    localparam logic [6:0] funct7_muldiv = 7'b0000001;  // M extension group
    localparam logic [2:0] funct3_addi   = 3'b000;
    localparam logic [2:0] funct3_mul    = 3'b000;
    localparam logic [2:0] funct3_divu   = 3'b101;

    typedef enum logic [2:0] {
        op_nop,
        op_lui,
        op_jal,
        op_jalr,
        op_addi,
        op_mul,
        op_divu
    } op_e;

    typedef enum logic [2:0] {
        st_fetch,
        st_wait_rsp,
        st_exec,
        st_jalr_calc,
        st_muldiv,
        st_retire
    } ctl_state_e;

endpackage

// File: logic/pc_control.sv
`timescale 1ns/1ns

module pc_control
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    output logic            fetch_start,
    input  logic            fetch_done,
    input  op_e             op,
    input  logic [4:0]      rd,
    input  logic [xlen-1:0] imm,
    input  logic [xlen-1:0] rs1_data,
    output logic            muldiv_start,
    input  logic            muldiv_done,
    input  logic [xlen-1:0] muldiv_result,
    output logic            rf_we,
    output logic [4:0]      rf_waddr,
    output logic [xlen-1:0] rf_wdata,
    output logic [xlen-1:0] fetch_pc,
    output logic            retire_valid,
    output logic [xlen-1:0] retire_pc,
    output logic [4:0]      retire_rd,
    output logic            retire_we,
    output logic [xlen-1:0] retire_data
);

    ctl_state_e      state;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] jalr_sum;
    logic [xlen-1:0] jalr_target;
    logic [xlen-1:0] next_pc;
    logic [xlen-1:0] wb_data;

    assign pc_plus4 = pc + xlen'(4);
    assign jalr_sum = rs1_data + imm;
    assign fetch_pc = pc;  // Held until retire, so the request address cannot move

    always_comb begin
        case (op)
            op_jal:  next_pc = pc + imm;
            op_jalr: next_pc = jalr_target;
            default: next_pc = pc_plus4;
        endcase
    end

    always_comb begin
        case (op)
            op_lui:          wb_data = imm;
            op_jal, op_jalr: wb_data = pc_plus4;  // Link address
            op_addi:         wb_data = jalr_sum;
            op_mul, op_divu: wb_data = muldiv_result;
            default:         wb_data = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= st_fetch;
            pc           <= reset_pc;
            fetch_start  <= 1'b0;
            muldiv_start <= 1'b0;
        end else begin
            fetch_start  <= 1'b0;
            muldiv_start <= 1'b0;
            case (state)
                st_fetch: begin
                    fetch_start <= 1'b1;
                    state       <= st_wait_rsp;
                end
                st_wait_rsp: begin
                    if (fetch_done) begin
                        state <= st_exec;
                    end
                end
                st_exec: begin
                    case (op)
                        op_jalr: state <= st_jalr_calc;
                        op_mul, op_divu: begin
                            muldiv_start <= 1'b1;
                            state        <= st_muldiv;
                        end
                        default: state <= st_retire;
                    endcase
                end
                st_jalr_calc: state <= st_retire;
                st_muldiv: begin
                    if (muldiv_done) begin
                        state <= st_retire;
                    end
                end
                st_retire: begin
                    pc    <= next_pc;
                    state <= st_fetch;
                end
                default: state <= st_fetch;
            endcase
        end
    end

    // Target is taken before rd is written, so rd equal to rs1 still sees the old value
    always_ff @(posedge clk) begin
        if (state == st_jalr_calc) begin
            jalr_target <= {jalr_sum[xlen-1:1], 1'b0};
        end
    end

    assign retire_valid = (state == st_retire);
    assign retire_pc    = pc;
    assign retire_rd    = rd;
    assign retire_we    = retire_valid && (rd != 5'd0);
    assign retire_data  = wb_data;

    assign rf_we    = retire_we;
    assign rf_waddr = rd;
    assign rf_wdata = wb_data;

endmodule

// File: logic/fetch_port.sv
`timescale 1ns/1ns

module fetch_port
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            fetch_start,
    input  logic [xlen-1:0] fetch_pc,
    output logic            imem_req_valid,
    output logic [xlen-1:0] imem_req_addr,
    input  logic            imem_req_ready,
    input  logic            imem_rsp_valid,
    input  logic [xlen-1:0] imem_rsp_data,
    output logic            fetch_done,
    output logic [xlen-1:0] instr
);

    typedef enum logic [1:0] {
        fp_idle,
        fp_req,
        fp_wait
    } fp_state_e;

    fp_state_e state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= fp_idle;
            imem_req_valid <= 1'b0;
            fetch_done     <= 1'b0;
        end else begin
            fetch_done <= 1'b0;
            case (state)
                fp_idle: begin
                    if (fetch_start) begin
                        imem_req_valid <= 1'b1;
                        state          <= fp_req;
                    end
                end
                fp_req: begin
                    if (imem_req_ready) begin  // Accepted on this edge
                        imem_req_valid <= 1'b0;
                        state          <= fp_wait;
                    end
                end
                fp_wait: begin
                    if (imem_rsp_valid) begin
                        fetch_done <= 1'b1;
                        state      <= fp_idle;
                    end
                end
                default: state <= fp_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == fp_idle && fetch_start) begin
            imem_req_addr <= fetch_pc;
        end
        if (state == fp_wait && imem_rsp_valid) begin
            instr <= imem_rsp_data;
        end
    end

endmodule

// File: logic/instr_decode.sv
`timescale 1ns/1ns

module instr_decode
    import core_pkg::*;
(
    input  logic [xlen-1:0] instr,
    output op_e             op,
    output logic [4:0]      rd,
    output logic [4:0]      rs1,
    output logic [4:0]      rs2,
    output logic [xlen-1:0] imm
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    assign imm_i = {{(xlen-12){instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{(xlen-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        op = op_nop;
        case (opcode)
            opc_lui:  op = op_lui;
            opc_jal:  op = op_jal;
            opc_jalr: op = op_jalr;
            opc_opimm: begin
                if (funct3 == funct3_addi) begin
                    op = op_addi;
                end
            end
            opc_op: begin
                if (funct7 == funct7_muldiv && funct3 == funct3_mul) begin
                    op = op_mul;
                end else if (funct7 == funct7_muldiv && funct3 == funct3_divu) begin
                    op = op_divu;
                end
            end
            default: op = op_nop;
        endcase
    end

    always_comb begin
        case (opcode)
            opc_lui: imm = imm_u;
            opc_jal: imm = imm_j;
            default: imm = imm_i;
        endcase
    end

    // Unsupported encodings retire with no destination
    assign rd = (op == op_nop) ? 5'd0 : instr[11:7];

endmodule

// File: logic/reg_file.sv
`timescale 1ns/1ns

module reg_file
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    output logic [xlen-1:0] rs1_data,
    output logic [xlen-1:0] rs2_data,
    input  logic            we,
    input  logic [4:0]      waddr,
    input  logic [xlen-1:0] wdata
);

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin  // x0 stays zero
            regs[waddr] <= wdata;
        end
    end

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

endmodule

// File: logic/muldiv_unit.sv
`timescale 1ns/1ns

module muldiv_unit
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  op_e             op,
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    output logic            busy,
    output logic            done,
    output logic [xlen-1:0] result
);

    logic [5:0]      cnt;
    logic            is_div;
    logic [xlen:0]   acc;       // Product, or partial remainder
    logic [xlen-1:0] opa;       // Multiplicand, or dividend shifting into quotient
    logic [xlen-1:0] opb;       // Multiplier, or divisor
    logic [xlen:0]   shifted;
    logic [xlen+1:0] diff;

    assign shifted = {acc[xlen-1:0], opa[xlen-1]};
    assign diff    = {1'b0, shifted} - {2'b00, opb};
    assign result  = is_div ? opa : acc[xlen-1:0];

    // Done lands muldiv_cycles+1 cycles after start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 6'd1;
                if (cnt == 6'(muldiv_cycles - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            is_div <= (op == op_divu);
            acc    <= '0;
            opa    <= a;
            opb    <= b;
        end else if (busy) begin
            if (is_div) begin
                // A zero divisor never borrows, so every quotient bit comes out one
                if (diff[xlen+1]) begin
                    acc <= shifted;
                    opa <= {opa[xlen-2:0], 1'b0};
                end else begin
                    acc <= diff[xlen:0];
                    opa <= {opa[xlen-2:0], 1'b1};
                end
            end else begin
                if (opb[0]) begin
                    acc <= acc + {1'b0, opa};
                end
                opa <= {opa[xlen-2:0], 1'b0};
                opb <= {1'b0, opb[xlen-1:1]};
            end
        end
    end

endmodule

// File: logic/fetch_core.sv
`timescale 1ns/1ns

module fetch_core
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    output logic            imem_req_valid,
    output logic [xlen-1:0] imem_req_addr,
    input  logic            imem_req_ready,
    input  logic            imem_rsp_valid,
    input  logic [xlen-1:0] imem_rsp_data,
    output logic            retire_valid,
    output logic [xlen-1:0] retire_pc,
    output logic [4:0]      retire_rd,
    output logic            retire_we,
    output logic [xlen-1:0] retire_data
);

    logic            fetch_start;
    logic            fetch_done;
    logic [xlen-1:0] fetch_pc;
    logic [xlen-1:0] instr;
    op_e             op;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic            muldiv_start;
    logic            muldiv_done;
    logic [xlen-1:0] muldiv_result;
    logic            rf_we;
    logic [4:0]      rf_waddr;
    logic [xlen-1:0] rf_wdata;

    pc_control i_pc_control (
        .clk(clk), .rst_n(rst_n),
        .fetch_start(fetch_start), .fetch_done(fetch_done),
        .op(op), .rd(rd), .imm(imm), .rs1_data(rs1_data),
        .muldiv_start(muldiv_start), .muldiv_done(muldiv_done),
        .muldiv_result(muldiv_result),
        .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
        .fetch_pc(fetch_pc),
        .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
        .retire_we(retire_we), .retire_data(retire_data)
    );

    fetch_port i_fetch_port (
        .clk(clk), .rst_n(rst_n),
        .fetch_start(fetch_start), .fetch_pc(fetch_pc),
        .imem_req_valid(imem_req_valid), .imem_req_addr(imem_req_addr),
        .imem_req_ready(imem_req_ready),
        .imem_rsp_valid(imem_rsp_valid), .imem_rsp_data(imem_rsp_data),
        .fetch_done(fetch_done), .instr(instr)
    );

    instr_decode i_instr_decode (
        .instr(instr), .op(op), .rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm)
    );

    reg_file i_reg_file (
        .clk(clk), .rst_n(rst_n),
        .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
    );

    muldiv_unit i_muldiv_unit (
        .clk(clk), .rst_n(rst_n),
        .start(muldiv_start), .op(op), .a(rs1_data), .b(rs2_data),
        .busy(), .done(muldiv_done), .result(muldiv_result)
    );

endmodule

// File: tests/fetch_core_properties.sv
`timescale 1ns/1ns

module fetch_core_properties
    import core_pkg::*;
(
    input logic            clk,
    input logic            rst_n,
    input logic            req_valid,
    input logic            req_ready,
    input logic [xlen-1:0] req_addr,
    input logic            rsp_valid,
    input logic            done_pulse
);

    int   fail_count = 0;  // Read by the testbench at the end of the run
    logic outstanding;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outstanding <= 1'b0;
        end else if (req_valid && req_ready) begin
            outstanding <= 1'b1;
        end else if (rsp_valid) begin
            outstanding <= 1'b0;
        end
    end

    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && !req_ready |=> req_valid && $stable(req_addr))
        else begin
            fail_count++;
            $error("request dropped or changed while stalled");
        end

    pulse_single: assert property (@(posedge clk) disable iff (!rst_n)
        done_pulse |=> !done_pulse)
        else begin
            fail_count++;
            $error("pulse held high for two cycles");
        end

    one_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        outstanding |-> !req_valid)
        else begin
            fail_count++;
            $error("request issued while a response is outstanding");
        end

endmodule

// The memory handshake, with fetch_done as the pulse
bind fetch_port fetch_core_properties i_fetch_props (
    .clk(clk), .rst_n(rst_n),
    .req_valid(imem_req_valid), .req_ready(imem_req_ready), .req_addr(imem_req_addr),
    .rsp_valid(imem_rsp_valid), .done_pulse(fetch_done)
);

// Inside the core the PC holds while the fetched word is awaited, and the FSM waits
// for no new word until the instruction in flight has retired
bind pc_control fetch_core_properties i_ctl_props (
    .clk(clk), .rst_n(rst_n),
    .req_valid(state == core_pkg::st_wait_rsp),
    .req_ready(fetch_done),
    .req_addr(fetch_pc),
    .rsp_valid(retire_valid), .done_pulse(retire_valid)
);

// File: tests/fetch_core_tb.sv
`timescale 1ns/1ns

module fetch_core_tb
    import core_pkg::*;
();

    logic            clk;
    logic            rst_n;
    logic            imem_req_valid;
    logic [xlen-1:0] imem_req_addr;
    logic            imem_req_ready;
    logic            imem_rsp_valid;
    logic [xlen-1:0] imem_rsp_data;
    logic            retire_valid;
    logic [xlen-1:0] retire_pc;
    logic [4:0]      retire_rd;
    logic            retire_we;
    logic [xlen-1:0] retire_data;

    logic [xlen-1:0] mem [logic [xlen-1:0]];  // Sparse instruction memory
    logic [xlen-1:0] m_regs [32];
    logic [xlen-1:0] m_pc;
    integer          seed;
    int              checks;
    int              errors;
    bit              aborted;

    fetch_core i_fetch_core (
        .clk(clk), .rst_n(rst_n),
        .imem_req_valid(imem_req_valid), .imem_req_addr(imem_req_addr),
        .imem_req_ready(imem_req_ready),
        .imem_rsp_valid(imem_rsp_valid), .imem_rsp_data(imem_rsp_data),
        .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
        .retire_we(retire_we), .retire_data(retire_data)
    );

    always #10 clk = ~clk;

    task automatic check_value(input string name, input logic [xlen-1:0] expected,
                               input logic [xlen-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("%s at %0t ns", what, $time);
    endtask

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, opc_jal};
    endfunction

    // Jumps only go forward, so every program reaches the loop at its end
    task automatic build_program(input int kind, input int n);
        logic [xlen-1:0] addr;
        logic [xlen-1:0] word;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        int              i;
        int              tgt;
        int unsigned     r;
        int unsigned     sel;
        mem.delete();
        mem[reset_pc] = {20'h80000, 5'd31, opc_lui};  // x31 keeps the program base for JALR
        for (i = 1; i < n - 1; i++) begin
            addr = reset_pc + xlen'(4 * i);
            word = $random(seed);
            rd   = 5'(rand_below(31));
            rs1  = word[19:15];
            rs2  = word[24:20];
            tgt  = i + 1 + int'(rand_below(n - 1 - i));
            r    = rand_below(7);
            case (kind)
                1: sel = r % 3;
                2: sel = (r % 3 == 0) ? 1 : r % 3 + 2;
                3: sel = (r % 4 < 2) ? r % 4 : r % 4 + 3;
                default: sel = r;
            endcase
            case (sel)
                0: mem[addr] = {word[31:12], rd, opc_lui};
                1: mem[addr] = enc_i(word[31:20], rs1, funct3_addi, rd, opc_opimm);
                2: mem[addr] = word[0] ? {word[31:12], rd, 7'b0010111}  // AUIPC
                                       : enc_i(word[31:20], rs1, 3'b100, rd, opc_opimm);
                3: mem[addr] = enc_j(21'(4 * (tgt - i)), rd);
                4: mem[addr] = enc_i(12'(4 * tgt) | 12'(word[0]), 5'd31, 3'b000, rd, opc_jalr);
                5: mem[addr] = enc_r(funct7_muldiv, rs2, rs1, funct3_mul, rd, opc_op);
                default: mem[addr] = enc_r(funct7_muldiv, word[1] ? 5'd0 : rs2, rs1,
                                           funct3_divu, rd, opc_op);
            endcase
        end
        mem[reset_pc + xlen'(4 * (n - 1))] = enc_j(21'd0, 5'd0);  // Jump to itself
    endtask

    task automatic model_step(input logic [xlen-1:0] ins, output logic [4:0] dst,
                              output logic [xlen-1:0] data, output logic [xlen-1:0] next_pc);
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] imm_i;
        logic            is_md;
        a       = m_regs[ins[19:15]];
        b       = m_regs[ins[24:20]];
        imm_i   = {{20{ins[31]}}, ins[31:20]};
        is_md   = (ins[6:0] == opc_op) && (ins[31:25] == funct7_muldiv);
        dst     = ins[11:7];
        data    = m_pc + xlen'(4);  // Link value of both jumps
        next_pc = m_pc + xlen'(4);
        if (ins[6:0] == opc_lui) begin
            data = {ins[31:12], 12'h000};
        end else if (ins[6:0] == opc_jal) begin
            next_pc = m_pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        end else if (ins[6:0] == opc_jalr) begin
            next_pc = (a + imm_i) & ~32'h1;
        end else if (ins[6:0] == opc_opimm && ins[14:12] == funct3_addi) begin
            data = a + imm_i;
        end else if (is_md && ins[14:12] == funct3_mul) begin
            data = a * b;
        end else if (is_md && ins[14:12] == funct3_divu) begin
            data = (b == 0) ? '1 : a / b;
        end else begin
            dst  = 5'd0;
            data = '0;
        end
        if (dst != 5'd0) begin
            m_regs[dst] = data;
        end
    endtask

    task automatic run_instr(input int max_delay, output bit at_end);
        logic [xlen-1:0] addr;
        logic [xlen-1:0] ins;
        logic [xlen-1:0] exp_data;
        logic [xlen-1:0] exp_next;
        logic [4:0]      exp_rd;
        int              cnt;
        at_end = 1'b0;
        cnt    = 0;
        while (!imem_req_valid && !aborted) begin
            if (retire_valid) begin
                report_problem("retire seen with no instruction in flight");
            end
            if (cnt == 200) begin
                report_problem("timeout waiting for an instruction request");
                aborted = 1'b1;
            end else begin
                @(negedge clk);
                cnt++;
            end
        end
        if (aborted) begin
            return;
        end
        addr = imem_req_addr;
        check_value("imem_req_addr", m_pc, addr);
        repeat (rand_below(max_delay + 1)) @(negedge clk);  // Back-pressure
        imem_req_ready = 1'b1;
        @(negedge clk);
        imem_req_ready = 1'b0;
        // Opcode zero decodes as a no-op if the core strays outside the program
        ins = mem.exists(addr) ? mem[addr] : {addr[31:7] ^ addr[24:0], 7'h00};
        repeat (rand_below(max_delay + 1)) begin
            if (retire_valid) begin
                report_problem("retire seen before the response");
            end
            @(negedge clk);
        end
        imem_rsp_valid = 1'b1;
        imem_rsp_data  = ins;
        @(negedge clk);
        imem_rsp_valid = 1'b0;
        model_step(ins, exp_rd, exp_data, exp_next);
        cnt = 0;
        while (!retire_valid && !aborted) begin
            if (imem_req_valid) begin
                report_problem("new request issued before the instruction retired");
                aborted = 1'b1;
            end else if (cnt == 100) begin
                report_problem("timeout waiting for retire_valid");
                aborted = 1'b1;
            end else begin
                @(negedge clk);
                cnt++;
            end
        end
        if (aborted) begin
            return;
        end
        check_value("retire_pc", m_pc, retire_pc);
        check_value("retire_rd", xlen'(exp_rd), xlen'(retire_rd));
        check_value("retire_we", xlen'(exp_rd != 5'd0), xlen'(retire_we));
        check_value("retire_data", exp_data, retire_data);
        at_end = (exp_next == m_pc);
        m_pc   = exp_next;
        @(negedge clk);
    endtask

    task automatic run_test(input string name, input int kind, input int n, input int max_delay);
        int first_errors;
        int retired;
        int i;
        bit at_end;
        if (aborted) begin
            return;
        end
        first_errors = errors;
        retired      = 0;
        at_end       = 1'b0;
        build_program(kind, n);
        for (i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        m_pc           = reset_pc;
        rst_n          = 1'b0;
        imem_req_ready = 1'b0;
        imem_rsp_valid = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        while (!at_end && !aborted && retired < 4 * n) begin
            run_instr(max_delay, at_end);
            retired++;
        end
        if (!at_end && !aborted) begin
            report_problem("program never reached its final loop");
        end
        $display("test %s: %0d instructions, %0d errors", name, retired, errors - first_errors);
    endtask

    initial begin
        seed           = 56344;
        clk            = 1'b0;
        rst_n          = 1'b0;
        imem_req_ready = 1'b0;
        imem_rsp_valid = 1'b0;
        imem_rsp_data  = '0;
        checks         = 0;
        errors         = 0;
        aborted        = 1'b0;
        run_test("reset_first_fetch", 0, 2, 6);
        run_test("straight_line", 1, 40, 0);
        run_test("jal_jalr", 2, 40, 0);
        run_test("mul_divu", 3, 24, 0);
        run_test("random_mix_stalled", 4, 60, 5);
        run_test("random_mix_long", 4, 120, 3);
        if (i_fetch_core.i_fetch_port.i_fetch_props.fail_count
            + i_fetch_core.i_pc_control.i_ctl_props.fail_count != 0) begin
            report_problem("bound assertions reported failures");
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: sources.f
logic/core_pkg.sv
logic/pc_control.sv
logic/fetch_port.sv
logic/instr_decode.sv
logic/reg_file.sv
logic/muldiv_unit.sv
logic/fetch_core.sv
tests/fetch_core_properties.sv
tests/fetch_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= fetch_core_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || echo "simulator exited with an error" >> $(LOG)
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG) || ! grep -q "sim passed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
